// ==== src/chip_io_pkg.sv ====
// Shared widths, control and status bit positions, and bus structs
// for the test chip control bridge. Referenced by scoped names only.

package chip_io_pkg;

    // ------------------------------------------------------------------
    // Widths
    localparam int AVS_WIDTH   = 32;
    localparam int ADDR_WIDTH  = 10;  // SRAM address
    localparam int DATA_WIDTH  = 8;   // SRAM data
    localparam int FRAME_WIDTH = ADDR_WIDTH + DATA_WIDTH;
    localparam int ADC_WIDTH   = 10;
    localparam int DIV_WIDTH   = 8;
    localparam logic [DIV_WIDTH-1:0] DEFAULT_DIV = '0;  // Half rate after reset

    // ------------------------------------------------------------------
    // Control word bit positions
    localparam int IDX_CTRL_BGN  = 0;
    localparam int IDX_CTRL_LOAD = 1;
    localparam int IDX_CTRL_MOD0 = 2;
    localparam int IDX_CTRL_MOD1 = 3;
    localparam int IDX_APP_DONE  = 4;
    localparam int IDX_CPU_BGN   = 5;
    localparam int IDX_RST_N     = 6;
    localparam int IDX_CPU_WAIT  = 7;
    localparam int IDX_TEST_MUX0 = 8;  // Three bits, 8 to 10
    localparam int IDX_CLK_STOP  = 11;
    localparam int IDX_CLK_CHG   = 12;

    // Status word bit positions
    localparam int IDX_CTRL_RDY  = 0;
    localparam int IDX_NXT_END   = 1;
    localparam int IDX_NXT_CONT  = 2;
    localparam int IDX_APP_START = 3;
    localparam int IDX_CTRL_SO   = 4;

    // ------------------------------------------------------------------
    // Serial link modes, SRAM modes are on-chip transfers
    typedef enum logic [1:0] {
        MODE_TO_CHIP   = 2'b00,
        MODE_SRAM_RD   = 2'b01,
        MODE_FROM_CHIP = 2'b10,
        MODE_SRAM_WR   = 2'b11
    } serial_mode_e;

    typedef struct packed {
        logic         ctrl_bgn;
        serial_mode_e mode;
        logic         rst_n;
        logic         cpu_wait;
        logic [2:0]   test_mux;
        logic         clk_stop;
        logic         clk_chg;
    } ctrl_word_t;

    // Address on top so frame bit 0 is data bit 0
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } sram_word_t;

    typedef struct packed {
        logic ctrl_rdy;
        logic nxt_end;
        logic nxt_cont;
        logic app_start;
        logic ctrl_so;
    } chip_status_t;

endpackage

// ==== src/ctrl_word_decode.sv ====
// Bus register file of the bridge. Holds control, SRAM, ADC and divider
// registers and turns the strobe bits of the control word into pulses.
`timescale 1ns/1ps

module ctrl_word_decode (
    input  logic                              csi_clk,
    input  logic                              rsi_reset_n,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_cpuctrl_writedata,
    input  logic                              avs_cpuctrl_write,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_sram_addr_wrt_writedata,
    input  logic                              avs_sram_addr_wrt_write,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_sram_data_wrt_writedata,
    input  logic                              avs_sram_data_wrt_write,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_adc_writedata,
    input  logic                              avs_adc_write,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_cntsclk_writedata,
    input  logic                              avs_cntsclk_write,
    output chip_io_pkg::ctrl_word_t           ctrl,
    output chip_io_pkg::sram_word_t           sram_word,
    output logic [chip_io_pkg::ADC_WIDTH-1:0] adc_value,
    output logic [chip_io_pkg::DIV_WIDTH-1:0] div_limit,
    output logic                              cpu_bgn_pulse,
    output logic                              load_pulse,
    output logic                              app_done_pulse
);

    logic [2:0] strb_q;   // Stored strobe bits {app_done, load, cpu_bgn}
    logic [2:0] fired_q;
    logic [2:0] pulse_q;

    // ------------------------------------------------------------------
    // Control word
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            ctrl   <= '0;
            strb_q <= '0;
        end
        else if (avs_cpuctrl_write)
        begin
            ctrl.ctrl_bgn <= avs_cpuctrl_writedata[chip_io_pkg::IDX_CTRL_BGN];
            ctrl.mode     <= chip_io_pkg::serial_mode_e'(
                                 {avs_cpuctrl_writedata[chip_io_pkg::IDX_CTRL_MOD1],
                                  avs_cpuctrl_writedata[chip_io_pkg::IDX_CTRL_MOD0]});
            ctrl.rst_n    <= avs_cpuctrl_writedata[chip_io_pkg::IDX_RST_N];
            ctrl.cpu_wait <= avs_cpuctrl_writedata[chip_io_pkg::IDX_CPU_WAIT];
            ctrl.test_mux <= avs_cpuctrl_writedata[chip_io_pkg::IDX_TEST_MUX0 +: 3];
            ctrl.clk_stop <= avs_cpuctrl_writedata[chip_io_pkg::IDX_CLK_STOP];
            ctrl.clk_chg  <= avs_cpuctrl_writedata[chip_io_pkg::IDX_CLK_CHG];
            strb_q <= {avs_cpuctrl_writedata[chip_io_pkg::IDX_APP_DONE],
                       avs_cpuctrl_writedata[chip_io_pkg::IDX_CTRL_LOAD],
                       avs_cpuctrl_writedata[chip_io_pkg::IDX_CPU_BGN]};
        end
    end

    // Data registers
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            sram_word <= '0;
            adc_value <= '0;
            div_limit <= chip_io_pkg::DEFAULT_DIV;
        end
        else
        begin
            if (avs_sram_addr_wrt_write)
                sram_word.addr <= avs_sram_addr_wrt_writedata[chip_io_pkg::ADDR_WIDTH-1:0];
            if (avs_sram_data_wrt_write)
                sram_word.data <= avs_sram_data_wrt_writedata[chip_io_pkg::DATA_WIDTH-1:0];
            if (avs_adc_write)
                adc_value <= avs_adc_writedata[chip_io_pkg::ADC_WIDTH-1:0];
            if (avs_cntsclk_write)
                div_limit <= avs_cntsclk_writedata[chip_io_pkg::DIV_WIDTH-1:0];
        end
    end

    // ------------------------------------------------------------------
    // One-cycle strobes, fire once per 0 to 1 change of the stored bit
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            fired_q <= '0;
            pulse_q <= '0;
        end
        else
        begin
            pulse_q <= strb_q & ~fired_q;
            fired_q <= strb_q;  // Clears once the bit is written back to 0
        end
    end

    assign cpu_bgn_pulse  = pulse_q[0];
    assign load_pulse     = pulse_q[1];
    assign app_done_pulse = pulse_q[2];

    // Strobes never stretch past one cycle
    a_strobe_one_cycle: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        (pulse_q & $past(pulse_q)) == 3'b000);

endmodule

// ==== src/chip_clock_gen.sv ====
// Chip clock source. Divides csi_clk by a programmable count and picks
// the bus clock, the divided clock or a stopped clock for the chip.
`timescale 1ns/1ps

module chip_clock_gen (
    input  logic                              csi_clk,
    input  logic                              rsi_reset_n,
    input  chip_io_pkg::ctrl_word_t           ctrl,
    input  logic [chip_io_pkg::DIV_WIDTH-1:0] div_limit,
    output logic                              coe_clk_export
);

    logic [chip_io_pkg::DIV_WIDTH-1:0] div_cnt;
    logic                              div_clk;   // Period 2*(div_limit+1)
    logic                              wrap;

    // Also catches a limit lowered below the running count
    assign wrap = (div_cnt >= div_limit);

    // ------------------------------------------------------------------
    // Divider
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            div_cnt <= '0;
            div_clk <= 1'b0;
        end
        else if (wrap)
        begin
            div_cnt <= '0;
            div_clk <= ~div_clk;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Clock select, stop wins over change
    always_comb
    begin
        if (ctrl.clk_stop)
            coe_clk_export = 1'b0;
        else if (ctrl.clk_chg)
            coe_clk_export = div_clk;
        else
            coe_clk_export = csi_clk;   // Bus clock straight through
    end

    // Divided clock only toggles right after the count equalled the limit,
    // unless the limit was just rewritten below the running count
    a_div_toggle: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        $changed(div_clk) |-> ($past(div_cnt) == $past(div_limit)) ||
                              ($past(div_limit) != $past(div_limit, 2)));

endmodule

// ==== src/serial_link.sv ====
// Serial frame link to the chip. Loads an SRAM address and data frame and
// shifts it out on si, or shifts a frame in from the chip's so pin.
`timescale 1ns/1ps

module serial_link (
    input  logic                      csi_clk,
    input  logic                      rsi_reset_n,
    input  chip_io_pkg::serial_mode_e mode,
    input  logic                      load_pulse,
    input  chip_io_pkg::sram_word_t   sram_word,
    input  chip_io_pkg::chip_status_t status,
    output chip_io_pkg::sram_word_t   frame
);

    localparam int CNT_WIDTH = $clog2(chip_io_pkg::FRAME_WIDTH);

    logic [CNT_WIDTH-1:0]               bit_cnt;   // Shifts still to go
    logic                               so_sync;
    logic [chip_io_pkg::FRAME_WIDTH-1:0] frame_shifted;

    assign so_sync = status.ctrl_so;

    // so enters at the top, si leaves from bit 0
    assign frame_shifted = {so_sync, frame[chip_io_pkg::FRAME_WIDTH-1:1]};

    // ------------------------------------------------------------------
    // Frame load and shift
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            frame   <= '0;
            bit_cnt <= '0;
        end
        else if (load_pulse)
        begin
            case (mode)
                chip_io_pkg::MODE_TO_CHIP:
                begin
                    frame   <= sram_word;
                    bit_cnt <= CNT_WIDTH'(chip_io_pkg::FRAME_WIDTH - 1);
                end
                chip_io_pkg::MODE_FROM_CHIP:
                begin
                    frame   <= chip_io_pkg::sram_word_t'(frame_shifted); // First bit in
                    bit_cnt <= CNT_WIDTH'(chip_io_pkg::FRAME_WIDTH - 1);
                end
                default:
                begin
                    // On-chip SRAM transfer, frame is held
                end
            endcase
        end
        else if (bit_cnt != '0)
        begin
            frame   <= chip_io_pkg::sram_word_t'(frame_shifted);
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    a_cnt_range: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        bit_cnt <= CNT_WIDTH'(chip_io_pkg::FRAME_WIDTH - 1));

endmodule

// ==== src/status_readback.sv ====
// Status path from the chip. Synchronizes the chip status pins and builds
// the status and frame readback words for the bus.
`timescale 1ns/1ps

module status_readback (
    input  logic                              csi_clk,
    input  logic                              rsi_reset_n,
    input  logic                              coe_ctrl_rdy_export,
    input  logic                              coe_ctrl_nxt_end_export,
    input  logic                              coe_ctrl_nxt_cont_export,
    input  logic                              coe_app_start_export,
    input  logic                              coe_ctrl_so_export,
    input  chip_io_pkg::sram_word_t           frame,
    output chip_io_pkg::chip_status_t         status,
    output logic [chip_io_pkg::AVS_WIDTH-1:0] avs_cpustat_readdata,
    output logic [chip_io_pkg::AVS_WIDTH-1:0] avs_sram_addr_rd_readdata,
    output logic [chip_io_pkg::AVS_WIDTH-1:0] avs_sram_data_rd_readdata
);

    chip_io_pkg::chip_status_t meta_q;   // First synchronizer stage

    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            meta_q <= '0;
            status <= '0;
        end
        else
        begin
            meta_q <= '{ctrl_rdy:  coe_ctrl_rdy_export,
                        nxt_end:   coe_ctrl_nxt_end_export,
                        nxt_cont:  coe_ctrl_nxt_cont_export,
                        app_start: coe_app_start_export,
                        ctrl_so:   coe_ctrl_so_export};
            status <= meta_q;
        end
    end

    // ------------------------------------------------------------------
    // Readback words
    always_comb
    begin
        avs_cpustat_readdata = '0;
        avs_cpustat_readdata[chip_io_pkg::IDX_CTRL_RDY]  = status.ctrl_rdy;
        avs_cpustat_readdata[chip_io_pkg::IDX_NXT_END]   = status.nxt_end;
        avs_cpustat_readdata[chip_io_pkg::IDX_NXT_CONT]  = status.nxt_cont;
        avs_cpustat_readdata[chip_io_pkg::IDX_APP_START] = status.app_start;
        avs_cpustat_readdata[chip_io_pkg::IDX_CTRL_SO]   = status.ctrl_so;
    end

    assign avs_sram_addr_rd_readdata = chip_io_pkg::AVS_WIDTH'(frame.addr);   // Zero-extend
    assign avs_sram_data_rd_readdata = chip_io_pkg::AVS_WIDTH'(frame.data);

endmodule

// ==== src/chip_io_ctrl.sv ====
// Top of the bus to test chip bridge. Connects the register decode, clock
// generator, serial link and status path to the bus ports and chip pins.
`timescale 1ns/1ps

module chip_io_ctrl (
    input  logic                              csi_clk,
    input  logic                              rsi_reset_n,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_cpuctrl_writedata,
    input  logic                              avs_cpuctrl_write,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_sram_addr_wrt_writedata,
    input  logic                              avs_sram_addr_wrt_write,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_sram_data_wrt_writedata,
    input  logic                              avs_sram_data_wrt_write,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_adc_writedata,
    input  logic                              avs_adc_write,
    input  logic [chip_io_pkg::AVS_WIDTH-1:0] avs_cntsclk_writedata,
    input  logic                              avs_cntsclk_write,
    output logic [chip_io_pkg::AVS_WIDTH-1:0] avs_cpustat_readdata,
    output logic [chip_io_pkg::AVS_WIDTH-1:0] avs_sram_addr_rd_readdata,
    output logic [chip_io_pkg::AVS_WIDTH-1:0] avs_sram_data_rd_readdata,
    output logic                              coe_cpu_bgn_export,
    output logic                              coe_ctrl_bgn_export,
    output logic                              coe_ctrl_mod0_export,
    output logic                              coe_ctrl_mod1_export,
    output logic                              coe_ctrl_load_export,
    output logic                              coe_ctrl_si_export,
    output logic                              coe_cpu_wait_export,
    output logic [chip_io_pkg::ADC_WIDTH-1:0] coe_adc_value_export,
    output logic                              coe_app_done_export,
    output logic                              coe_rst_n_export,
    output logic                              coe_clk_export,
    output logic                              coe_test_mux0_export,
    output logic                              coe_test_mux1_export,
    output logic                              coe_test_mux2_export,
    input  logic                              coe_ctrl_so_export,
    input  logic                              coe_ctrl_rdy_export,
    input  logic                              coe_ctrl_nxt_end_export,
    input  logic                              coe_ctrl_nxt_cont_export,
    input  logic                              coe_app_start_export
);

    chip_io_pkg::ctrl_word_t           ctrl;
    chip_io_pkg::sram_word_t           sram_word;
    chip_io_pkg::sram_word_t           frame;
    chip_io_pkg::chip_status_t         status;
    logic [chip_io_pkg::DIV_WIDTH-1:0] div_limit;
    logic [1:0]                        mode_bits;
    logic                              load_pulse;

    ctrl_word_decode ctrl_word_decode_i (
        .csi_clk, .rsi_reset_n,
        .avs_cpuctrl_writedata, .avs_cpuctrl_write,
        .avs_sram_addr_wrt_writedata, .avs_sram_addr_wrt_write,
        .avs_sram_data_wrt_writedata, .avs_sram_data_wrt_write,
        .avs_adc_writedata, .avs_adc_write,
        .avs_cntsclk_writedata, .avs_cntsclk_write,
        .ctrl, .sram_word, .adc_value(coe_adc_value_export), .div_limit,
        .cpu_bgn_pulse(coe_cpu_bgn_export), .load_pulse,
        .app_done_pulse(coe_app_done_export)
    );

    chip_clock_gen chip_clock_gen_i (
        .csi_clk, .rsi_reset_n, .ctrl, .div_limit, .coe_clk_export
    );

    serial_link serial_link_i (
        .csi_clk, .rsi_reset_n, .mode(ctrl.mode), .load_pulse,
        .sram_word, .status, .frame
    );

    status_readback status_readback_i (
        .csi_clk, .rsi_reset_n,
        .coe_ctrl_rdy_export, .coe_ctrl_nxt_end_export, .coe_ctrl_nxt_cont_export,
        .coe_app_start_export, .coe_ctrl_so_export,
        .frame, .status,
        .avs_cpustat_readdata, .avs_sram_addr_rd_readdata, .avs_sram_data_rd_readdata
    );

    // ------------------------------------------------------------------
    // Chip pins
    assign mode_bits            = ctrl.mode;
    assign coe_ctrl_bgn_export  = ctrl.ctrl_bgn;
    assign coe_ctrl_mod0_export = mode_bits[0];
    assign coe_ctrl_mod1_export = mode_bits[0] & mode_bits[1];  // Only in SRAM modes
    assign coe_ctrl_load_export = ~load_pulse;                   // Active low on chip
    assign coe_ctrl_si_export   = frame.data[0];
    assign coe_cpu_wait_export  = ctrl.cpu_wait;
    assign coe_rst_n_export     = ctrl.rst_n;
    assign coe_test_mux0_export = ctrl.test_mux[0];
    assign coe_test_mux1_export = ctrl.test_mux[1];
    assign coe_test_mux2_export = ctrl.test_mux[2];

endmodule

// ==== tests/chip_io_ctrl_tb.sv ====
// Testbench for the test chip control bridge. Walks reset, control levels,
// strobes, serial frames, status, ADC and chip clock through the top level.
`timescale 1ns/1ps

module chip_io_ctrl_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int CLK_HALF        = CLK_PERIOD / 2;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = 2000;   // Well beyond the full sequence
    localparam int REG_CTRL        = 0;
    localparam int REG_ADDR        = 1;
    localparam int REG_DATA        = 2;
    localparam int REG_ADC         = 3;
    localparam int REG_DIV         = 4;
    localparam logic [31:0] STROBE_WORD = 32'h0000_0076;   // All strobes, SRAM read mode

    logic        csi_clk;
    logic        rsi_reset_n;
    logic [31:0] avs_cpuctrl_writedata;
    logic        avs_cpuctrl_write;
    logic [31:0] avs_sram_addr_wrt_writedata;
    logic        avs_sram_addr_wrt_write;
    logic [31:0] avs_sram_data_wrt_writedata;
    logic        avs_sram_data_wrt_write;
    logic [31:0] avs_adc_writedata;
    logic        avs_adc_write;
    logic [31:0] avs_cntsclk_writedata;
    logic        avs_cntsclk_write;
    logic [31:0] avs_cpustat_readdata;
    logic [31:0] avs_sram_addr_rd_readdata;
    logic [31:0] avs_sram_data_rd_readdata;
    logic        coe_cpu_bgn_export;
    logic        coe_ctrl_bgn_export;
    logic        coe_ctrl_mod0_export;
    logic        coe_ctrl_mod1_export;
    logic        coe_ctrl_load_export;
    logic        coe_ctrl_si_export;
    logic        coe_cpu_wait_export;
    logic [9:0]  coe_adc_value_export;
    logic        coe_app_done_export;
    logic        coe_rst_n_export;
    logic        coe_clk_export;
    logic        coe_test_mux0_export;
    logic        coe_test_mux1_export;
    logic        coe_test_mux2_export;
    logic        coe_ctrl_so_export;
    logic        coe_ctrl_rdy_export;
    logic        coe_ctrl_nxt_end_export;
    logic        coe_ctrl_nxt_cont_export;
    logic        coe_app_start_export;

    logic [31:0] lfsr_state;
    logic [7:0]  level_pins;    // ctrl_bgn, mod0, mod1, rst_n, cpu_wait, test_mux[2:0]
    logic [2:0]  strobe_pins;   // Active high view of cpu_bgn, app_done, load

    chip_io_ctrl chip_io_ctrl_i (.*);

    assign level_pins  = {coe_ctrl_bgn_export, coe_ctrl_mod0_export, coe_ctrl_mod1_export,
                          coe_rst_n_export, coe_cpu_wait_export, coe_test_mux2_export,
                          coe_test_mux1_export, coe_test_mux0_export};
    assign strobe_pins = {coe_cpu_bgn_export, coe_app_done_export, ~coe_ctrl_load_export};

    always #(CLK_HALF) csi_clk = ~csi_clk;

    // ----------------------------------------------------------------------
    // Reporting and stimulus helpers
    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("FAIL %s expected 0x%0h actual 0x%0h",
                                test, expected, actual));
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else report_mismatch(test, expected, actual);
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [7:0] expected_levels(input logic [31:0] w);
        expected_levels = {w[0], w[2], w[3] & w[2], w[6], w[7], w[10:8]};   // mod1 gated
    endfunction

    task automatic next_cycle();
        @(posedge csi_clk);
        #(DRIVE_DELAY);
    endtask

    // Write strobe sampled at the next edge, returns just after it
    task automatic bus_write(input int sel, input logic [31:0] value);
        avs_cpuctrl_writedata       = value;
        avs_sram_addr_wrt_writedata = value;
        avs_sram_data_wrt_writedata = value;
        avs_adc_writedata           = value;
        avs_cntsclk_writedata       = value;
        avs_cpuctrl_write           = (sel == REG_CTRL);
        avs_sram_addr_wrt_write     = (sel == REG_ADDR);
        avs_sram_data_wrt_write     = (sel == REG_DATA);
        avs_adc_write               = (sel == REG_ADC);
        avs_cntsclk_write           = (sel == REG_DIV);
        next_cycle();
        avs_cpuctrl_write       = 1'b0;
        avs_sram_addr_wrt_write = 1'b0;
        avs_sram_data_wrt_write = 1'b0;
        avs_adc_write           = 1'b0;
        avs_cntsclk_write       = 1'b0;
    endtask

    // Idle at the write edge, one cycle high after the next edge
    task automatic check_strobes(input string test);
        check_value({test, "_idle"}, 3'b000, strobe_pins);
        next_cycle();
        check_value({test, "_pulse"}, 3'b111, strobe_pins);
        next_cycle();
        check_value({test, "_after"}, 3'b000, strobe_pins);
    endtask

    task automatic wait_load_strobe(input string test);
        int n;
        n = 0;
        while (coe_ctrl_load_export !== 1'b0 && n < 8)
        begin
            next_cycle();
            n++;
        end
        assert (coe_ctrl_load_export === 1'b0)
        else stop_on_error({test, ": load strobe never showed on coe_ctrl_load_export"});
    endtask

    task automatic check_clock_follows();
        check_value("reset_clock_high", 1, coe_clk_export);
        #(CLK_HALF);
        check_value("reset_clock_low", 0, coe_clk_export);
        next_cycle();
    endtask

    task automatic check_divided_clock(input int half_cycles);
        logic level;
        int   n;
        int   run;
        level = coe_clk_export;   // First run may be partial, skip it
        n = 0;
        while (coe_clk_export === level && n < 64)
        begin
            next_cycle();
            n++;
        end
        for (run = 0; run < 4; run++)
        begin
            level = coe_clk_export;
            n = 0;
            while (coe_clk_export === level && n < 64)
            begin
                next_cycle();
                n++;
            end
            check_value("clock_divided_level", half_cycles, n);
        end
    endtask

    task automatic check_clock_stopped(input int cycles);
        repeat (cycles)
        begin
            check_value("clock_stop_high_phase", 0, coe_clk_export);
            #(CLK_HALF);
            check_value("clock_stop_low_phase", 0, coe_clk_export);
            next_cycle();
        end
    endtask

    // ----------------------------------------------------------------------
    // Properties watched on every cycle
    a_mod1_gated: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        !coe_ctrl_mod0_export |-> !coe_ctrl_mod1_export)
        else report_mismatch("mod1_gated", 0, 1);

    a_load_one_cycle: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        !coe_ctrl_load_export |=> coe_ctrl_load_export)
        else report_mismatch("load_strobe_width", 1, 0);

    a_cpu_bgn_one_cycle: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        coe_cpu_bgn_export |=> !coe_cpu_bgn_export)
        else report_mismatch("cpu_bgn_strobe_width", 0, 1);

    a_app_done_one_cycle: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        coe_app_done_export |=> !coe_app_done_export)
        else report_mismatch("app_done_strobe_width", 0, 1);

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("Watchdog expired before the test sequence finished");
    end

    // ----------------------------------------------------------------------
    // Main sequence
    initial
    begin
        logic [31:0] word;
        logic [31:0] addr;
        logic [31:0] data;
        logic [17:0] exp_frame;
        int          i;

        lfsr_state               = 32'h8f30;
        csi_clk                  = 1'b0;
        rsi_reset_n              = 1'b0;
        avs_cpuctrl_writedata    = '0;
        avs_cpuctrl_write        = 1'b0;
        avs_sram_addr_wrt_writedata = '0;
        avs_sram_addr_wrt_write  = 1'b0;
        avs_sram_data_wrt_writedata = '0;
        avs_sram_data_wrt_write  = 1'b0;
        avs_adc_writedata        = '0;
        avs_adc_write            = 1'b0;
        avs_cntsclk_writedata    = '0;
        avs_cntsclk_write        = 1'b0;
        coe_ctrl_so_export       = 1'b0;
        coe_ctrl_rdy_export      = 1'b0;
        coe_ctrl_nxt_end_export  = 1'b0;
        coe_ctrl_nxt_cont_export = 1'b0;
        coe_app_start_export     = 1'b0;

        repeat (RESET_CYCLES) @(posedge csi_clk);
        #(DRIVE_DELAY);
        rsi_reset_n = 1'b1;

        check_value("reset_rst_n", 0, coe_rst_n_export);
        check_value("reset_cpu_bgn", 0, coe_cpu_bgn_export);
        check_value("reset_app_done", 0, coe_app_done_export);
        check_value("reset_load_n", 1, coe_ctrl_load_export);
        check_value("reset_cpustat_rd", 0, avs_cpustat_readdata);
        check_value("reset_addr_rd", 0, avs_sram_addr_rd_readdata);
        check_value("reset_data_rd", 0, avs_sram_data_rd_readdata);
        check_clock_follows();

        for (i = 0; i < 8; i++)
        begin
            take_random(15, word);   // Bits 13 and 14 are ignored by the DUT
            bus_write(REG_CTRL, word);
            check_value("ctrl_levels", expected_levels(word), level_pins);
            next_cycle();
            check_value("ctrl_levels_hold", expected_levels(word), level_pins);
        end

        bus_write(REG_CTRL, 32'h0000_0040);
        next_cycle();
        bus_write(REG_CTRL, STROBE_WORD);
        check_strobes("strobe_first");
        bus_write(REG_CTRL, STROBE_WORD);   // Same word again, no retrigger
        repeat (3)
        begin
            check_value("strobe_no_repeat", 3'b000, strobe_pins);
            next_cycle();
        end
        bus_write(REG_CTRL, 32'h0000_0040);
        bus_write(REG_CTRL, STROBE_WORD);
        check_strobes("strobe_rearm");

        // Frame out, so held at 0
        bus_write(REG_CTRL, 32'h0000_0040);
        take_random(10, addr);
        take_random(8, data);
        exp_frame = {addr[9:0], data[7:0]};
        bus_write(REG_ADDR, addr);
        bus_write(REG_DATA, data);
        bus_write(REG_CTRL, 32'h0000_0042);
        wait_load_strobe("frame_out");
        for (i = 0; i < 18; i++)
        begin
            next_cycle();
            check_value("frame_out_si", exp_frame[i], coe_ctrl_si_export);
        end
        // Only 17 shifts follow the load, so the last bit out stays at bit 0
        check_value("frame_out_addr_rd", 0, avs_sram_addr_rd_readdata);
        check_value("frame_out_data_rd", exp_frame[17], avs_sram_data_rd_readdata);

        coe_ctrl_so_export = 1'b1;
        bus_write(REG_CTRL, 32'h0000_0048);
        bus_write(REG_CTRL, 32'h0000_004A);
        wait_load_strobe("frame_in");
        repeat (18) next_cycle();
        check_value("frame_in_addr_rd", 32'h3FF, avs_sram_addr_rd_readdata);
        check_value("frame_in_data_rd", 32'hFF, avs_sram_data_rd_readdata);

        for (i = 0; i < 4; i++)
        begin
            take_random(5, word);
            coe_ctrl_rdy_export      = word[0];
            coe_ctrl_nxt_end_export  = word[1];
            coe_ctrl_nxt_cont_export = word[2];
            coe_app_start_export     = word[3];
            coe_ctrl_so_export       = word[4];
            next_cycle();
            next_cycle();   // Two synchronizer stages
            check_value("status_word", word[4:0], avs_cpustat_readdata);
        end

        take_random(32, word);
        bus_write(REG_ADC, word);
        check_value("adc_value", word[9:0], coe_adc_value_export);

        bus_write(REG_DIV, 32'd2);
        bus_write(REG_CTRL, 32'h0000_1040);
        check_divided_clock(3);   // Limit plus one per level
        bus_write(REG_CTRL, 32'h0000_0840);
        check_clock_stopped(8);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== flist.f ====
src/chip_io_pkg.sv
src/ctrl_word_decode.sv
src/chip_clock_gen.sv
src/serial_link.sv
src/status_readback.sv
src/chip_io_ctrl.sv
tests/chip_io_ctrl_tb.sv
